/* core_pkg.sv */
//------------------------------------------------
// Word-only ISA, eight registers, r0 reads zero
// Opcode in [31:28], rd/rs1/rs2 below it, imm in [15:0]
//------------------------------------------------
package core_pkg;

  localparam int WordWidth = 32;
  localparam int ImmWidth  = 16;
  localparam int NumRegs   = 8;

  typedef logic [WordWidth-1:0] word_t;
  typedef logic [WordWidth-1:0] instr_t;
  typedef logic [2:0]           reg_idx_t;
  typedef logic [ImmWidth-1:0]  imm_t;

  typedef enum logic [3:0] {
    OP_ADDI  = 4'h1,
    OP_ADD   = 4'h2,
    OP_SUB   = 4'h3,
    OP_AND   = 4'h4,
    OP_LW    = 4'h5,
    OP_SW    = 4'h6,
    OP_BEQ   = 4'h7,
    OP_ECALL = 4'h8
  } opcode_e;

  // Instruction field positions
  localparam int OpcMsb = 31;
  localparam int OpcLsb = 28;
  localparam int RdMsb  = 27;
  localparam int RdLsb  = 25;
  localparam int Rs1Msb = 24;
  localparam int Rs1Lsb = 22;
  localparam int Rs2Msb = 21;
  localparam int Rs2Lsb = 19;
  localparam int ImmMsb = 15;
  localparam int ImmLsb = 0;

endpackage

/* exec_unit.sv */
`timescale 1ns/1ps
//------------------------------------------------
// One instruction at a time; ECALL is never consumed
// Unknown opcodes retire as no-ops
//------------------------------------------------
module exec_unit (
  input  logic  clk,
  input  logic  arst_n_i,
  fetch_if.exec fetch_bus,
  lsu_if.exec   lsu_bus,
  output logic  halt_o
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    EXEC_RUN,
    EXEC_WAIT_MEM,
    EXEC_HALTED
  } exec_state_e;

  exec_state_e state_q;
  exec_state_e state_d;
  word_t       regs_q [NumRegs];
  opcode_e     opcode;
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  imm_t        imm;
  word_t       imm_sext;
  word_t       rs1_val;
  word_t       rs2_val;
  word_t       alu_res;
  logic        rf_we;
  word_t       rf_wdata;

  // Fields of the held instruction, stable until consumed
  assign opcode   = opcode_e'(fetch_bus.instr[OpcMsb:OpcLsb]);
  assign rd       = fetch_bus.instr[RdMsb:RdLsb];
  assign rs1      = fetch_bus.instr[Rs1Msb:Rs1Lsb];
  assign rs2      = fetch_bus.instr[Rs2Msb:Rs2Lsb];
  assign imm      = fetch_bus.instr[ImmMsb:ImmLsb];
  assign imm_sext = {{(WordWidth-ImmWidth){imm[ImmWidth-1]}}, imm};

  assign rs1_val = regs_q[rs1];
  assign rs2_val = regs_q[rs2];

  always_comb begin
    case (opcode)
      OP_ADD:  alu_res = rs1_val + rs2_val;
      OP_SUB:  alu_res = rs1_val - rs2_val;
      OP_AND:  alu_res = rs1_val & rs2_val;
      // ADDI result, also the LW/SW address
      default: alu_res = rs1_val + imm_sext;
    endcase
  end

  always_comb begin
    state_d               = state_q;
    fetch_bus.instr_ready = 1'b0;
    fetch_bus.redirect    = 1'b0;
    lsu_bus.cmd_valid     = 1'b0;
    rf_we                 = 1'b0;
    rf_wdata              = alu_res;
    case (state_q)
      EXEC_RUN: begin
        if (fetch_bus.instr_valid) begin
          case (opcode)
            OP_ADDI, OP_ADD, OP_SUB, OP_AND: begin
              rf_we                 = 1'b1;
              fetch_bus.instr_ready = 1'b1;
            end
            OP_LW, OP_SW: begin
              lsu_bus.cmd_valid = 1'b1;
              state_d           = EXEC_WAIT_MEM;
            end
            OP_BEQ: begin
              fetch_bus.instr_ready = 1'b1;
              fetch_bus.redirect    = (rs1_val == rs2_val);
            end
            OP_ECALL: state_d = EXEC_HALTED;
            default:  fetch_bus.instr_ready = 1'b1;
          endcase
        end
      end
      EXEC_WAIT_MEM: begin
        // Consume the load/store only once the bus access is complete
        if (lsu_bus.done) begin
          fetch_bus.instr_ready = 1'b1;
          rf_we                 = (opcode == OP_LW);
          rf_wdata              = lsu_bus.rdata;
          state_d               = EXEC_RUN;
        end
      end
      default: ;
    endcase
  end

  // Branch offset counts words
  assign fetch_bus.redirect_pc = fetch_bus.pc + {imm_sext[WordWidth-3:0], 2'b00};

  assign lsu_bus.cmd_we    = (opcode == OP_SW);
  assign lsu_bus.cmd_addr  = alu_res;
  assign lsu_bus.cmd_wdata = rs2_val;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= EXEC_RUN;
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      state_q <= state_d;
      // r0 is never written
      if (rf_we && rd != '0) begin
        regs_q[rd] <= rf_wdata;
      end
    end
  end

  assign halt_o = (state_q == EXEC_HALTED);

endmodule

/* fetch_if.sv */
`timescale 1ns/1ps
//------------------------------------------------
// instr_valid holds until instr_ready consumes it
//------------------------------------------------
interface fetch_if;
  import core_pkg::*;

  logic   instr_valid;
  instr_t instr;
  word_t  pc;
  logic   instr_ready;
  // Only raised together with instr_ready by the execute side
  logic   redirect;
  word_t  redirect_pc;

  modport fetch (
    output instr_valid, instr, pc,
    input  instr_ready, redirect, redirect_pc
  );

  modport exec (
    input  instr_valid, instr, pc,
    output instr_ready, redirect, redirect_pc
  );

endinterface

/* fetch_unit.sv */
`timescale 1ns/1ps
//------------------------------------------------
// One fetch outstanding; halt stops fetching until reset
//------------------------------------------------
module fetch_unit #(
  parameter core_pkg::word_t BootAddr = '0
) (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             fetch_enable_i,
  input  logic             halt_i,
  output logic             instr_req_o,
  input  logic             instr_gnt_i,
  output core_pkg::word_t  instr_addr_o,
  input  logic             instr_rvalid_i,
  input  core_pkg::instr_t instr_rdata_i,
  fetch_if.fetch           fetch_bus
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_WAIT,
    FETCH_HOLD
  } fetch_state_e;

  fetch_state_e state_q;
  word_t        pc_q;      // next fetch address
  word_t        addr_q;    // address on the bus, then pc of the held word
  instr_t       instr_q;
  word_t        next_pc;

  assign next_pc = fetch_bus.redirect ? fetch_bus.redirect_pc : addr_q + 32'd4;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= FETCH_IDLE;
      pc_q    <= BootAddr;
      addr_q  <= BootAddr;
    end else begin
      case (state_q)
        FETCH_IDLE: begin
          if (fetch_enable_i && !halt_i) begin
            addr_q  <= pc_q;
            state_q <= FETCH_REQ;
          end
        end
        FETCH_REQ: begin
          if (instr_gnt_i) begin
            state_q <= FETCH_WAIT;
          end
        end
        FETCH_WAIT: begin
          if (instr_rvalid_i) begin
            state_q <= FETCH_HOLD;
          end
        end
        default: begin
          if (halt_i) begin
            state_q <= FETCH_IDLE;
          end else if (fetch_bus.instr_ready) begin
            pc_q    <= next_pc;
            addr_q  <= next_pc;
            state_q <= FETCH_REQ;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == FETCH_WAIT && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o           = (state_q == FETCH_REQ);
  assign instr_addr_o          = addr_q;
  assign fetch_bus.instr_valid = (state_q == FETCH_HOLD);
  assign fetch_bus.instr       = instr_q;
  assign fetch_bus.pc          = addr_q;

endmodule

/* list.f */
core_pkg.sv
fetch_if.sv
lsu_if.sv
fetch_unit.sv
exec_unit.sv
lsu.sv
tiny_core.sv
tb_tiny_core.sv

/* lsu.sv */
`timescale 1ns/1ps
//------------------------------------------------
// Whole-word accesses only; commands while busy are ignored
//------------------------------------------------
module lsu (
  input  logic            clk,
  input  logic            arst_n_i,
  output logic            data_req_o,
  input  logic            data_gnt_i,
  output logic            data_we_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  logic            data_rvalid_i,
  input  core_pkg::word_t data_rdata_i,
  lsu_if.lsu              lsu_bus
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_REQ,
    LSU_WAIT
  } lsu_state_e;

  lsu_state_e state_q;
  logic       done_q;
  logic       we_q;
  word_t      addr_q;
  word_t      wdata_q;
  word_t      rdata_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= LSU_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= (state_q == LSU_WAIT) && data_rvalid_i;
      case (state_q)
        LSU_IDLE: if (lsu_bus.cmd_valid) state_q <= LSU_REQ;
        LSU_REQ:  if (data_gnt_i) state_q <= LSU_WAIT;
        default:  if (data_rvalid_i) state_q <= LSU_IDLE;
      endcase
    end
  end

  // Command and response payload
  always_ff @(posedge clk) begin
    if (state_q == LSU_IDLE && lsu_bus.cmd_valid) begin
      we_q    <= lsu_bus.cmd_we;
      addr_q  <= lsu_bus.cmd_addr;
      wdata_q <= lsu_bus.cmd_wdata;
    end
    if (state_q == LSU_WAIT && data_rvalid_i) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign data_req_o    = (state_q == LSU_REQ);
  assign data_we_o     = we_q;
  assign data_addr_o   = addr_q;
  assign data_wdata_o  = wdata_q;
  assign lsu_bus.done  = done_q;
  assign lsu_bus.rdata = rdata_q;

endmodule

/* lsu_if.sv */
`timescale 1ns/1ps
//------------------------------------------------
// cmd_valid and done are single-cycle pulses
// One command in flight at a time
//------------------------------------------------
interface lsu_if;
  import core_pkg::*;

  logic  cmd_valid;
  logic  cmd_we;
  word_t cmd_addr;
  word_t cmd_wdata;
  logic  done;
  // Valid in the done cycle only
  word_t rdata;

  modport exec (
    output cmd_valid, cmd_we, cmd_addr, cmd_wdata,
    input  done, rdata
  );

  modport lsu (
    input  cmd_valid, cmd_we, cmd_addr, cmd_wdata,
    output done, rdata
  );

endinterface

/* run.sh */
#!/bin/sh
# Builds the tiny_core testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f list.f \
  --top-module tb_tiny_core -o sim_tb_tiny_core

out=$(./obj_dir/sim_tb_tiny_core)
echo "$out"

# Exit status follows the search for the pass line
echo "$out" | grep -q "Simulation finished: PASS"

/* tb_tiny_core.sv */
`timescale 1ns/1ps
//------------------------------------------------
// Memories hold 64 words, so addresses wrap at 0x100
// Data words at 0x40..0x4C are loaded from the table
//------------------------------------------------
module tb_tiny_core;
  import core_pkg::*;

  localparam int NumTests = 3;
  localparam int ProgLen  = 12;
  localparam int Timeout  = NumTests * 400 * 4;

  logic   clk            = 1'b0;
  logic   arst_n_i       = 1'b0;
  logic   fetch_enable_i = 1'b0;
  logic   instr_req_o;
  logic   instr_gnt_i    = 1'b0;
  word_t  instr_addr_o;
  logic   instr_rvalid_i = 1'b0;
  instr_t instr_rdata_i  = '0;
  logic   data_req_o;
  logic   data_gnt_i     = 1'b0;
  logic   data_we_o;
  word_t  data_addr_o;
  word_t  data_wdata_o;
  logic   data_rvalid_i  = 1'b0;
  word_t  data_rdata_i   = '0;
  logic   core_sleep_o;

  // Test table
  string  t_name    [NumTests];
  instr_t t_prog    [NumTests][ProgLen];
  word_t  t_dmem    [NumTests][4];
  int     t_nstores [NumTests];
  word_t  t_st_addr [NumTests][4];
  word_t  t_st_data [NumTests][4];

  instr_t imem [64];
  word_t  dmem [64];
  word_t  st_addr_q [$];
  word_t  st_data_q [$];
  int     cur_test = 0;
  int     errors   = 0;
  int     seed     = 12737;

  // Bus model state
  logic   bus_rst;
  logic   i_pend;
  logic   d_pend;
  int     i_delay;
  int     d_delay;
  word_t  i_addr;
  word_t  d_addr;

  tiny_core #(
    .BootAddr('0)
  ) i_tiny_core (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .fetch_enable_i(fetch_enable_i),
    .instr_req_o   (instr_req_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_addr_o  (instr_addr_o),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_we_o     (data_we_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .core_sleep_o  (core_sleep_o)
  );

  always #2 clk = ~clk;

  function automatic instr_t encode(opcode_e op, int rd, int rs1, int rs2, int imm);
    instr_t w;
    w = '0;
    w[OpcMsb:OpcLsb] = op;
    w[RdMsb:RdLsb]   = reg_idx_t'(rd);
    w[Rs1Msb:Rs1Lsb] = reg_idx_t'(rs1);
    w[Rs2Msb:Rs2Lsb] = reg_idx_t'(rs2);
    w[ImmMsb:ImmLsb] = imm_t'(imm);
    return w;
  endfunction

  // Grant delay of 0 to 2 cycles
  function automatic int draw_delay();
    return $unsigned($random(seed)) % 3;
  endfunction

  task automatic add_store(input int t, input word_t addr, input word_t data);
    t_st_addr[t][t_nstores[t]] = addr;
    t_st_data[t][t_nstores[t]] = data;
    t_nstores[t]++;
  endtask

  task automatic build_table();
    for (int t = 0; t < NumTests; t++) begin
      t_nstores[t] = 0;
      for (int i = 0; i < ProgLen; i++) begin
        t_prog[t][i] = encode(OP_ECALL, 0, 0, 0, 0);
      end
      for (int k = 0; k < 4; k++) begin
        t_dmem[t][k] = 32'hc0de_0000 + word_t'(k);
      end
    end
    // ALU ops with wrap-around and a write to r0
    t_name[0]    = "alu_ops";
    t_prog[0][0] = encode(OP_ADDI, 1, 0, 0, 5);
    t_prog[0][1] = encode(OP_ADDI, 2, 0, 0, -3);
    t_prog[0][2] = encode(OP_ADD, 3, 1, 2, 0);
    t_prog[0][3] = encode(OP_SUB, 4, 2, 1, 0);
    t_prog[0][4] = encode(OP_AND, 5, 2, 1, 0);
    t_prog[0][5] = encode(OP_ADDI, 0, 0, 0, 7);
    t_prog[0][6] = encode(OP_SW, 0, 0, 3, 'h40);
    t_prog[0][7] = encode(OP_SW, 0, 0, 4, 'h44);
    t_prog[0][8] = encode(OP_SW, 0, 0, 5, 'h48);
    t_prog[0][9] = encode(OP_SW, 0, 0, 0, 'h4c);
    add_store(0, 32'h40, 32'h0000_0002);
    add_store(0, 32'h44, 32'hffff_fff8);
    add_store(0, 32'h48, 32'h0000_0005);
    add_store(0, 32'h4c, 32'h0000_0000);
    // Loads feeding adds
    t_name[1]    = "load_add";
    t_dmem[1][0] = 32'h1234_5678;
    t_dmem[1][1] = 32'hffff_ff00;
    t_prog[1][0] = encode(OP_ADDI, 1, 0, 0, 'h40);
    t_prog[1][1] = encode(OP_LW, 2, 1, 0, 0);
    t_prog[1][2] = encode(OP_ADDI, 3, 0, 0, 'h10);
    t_prog[1][3] = encode(OP_ADD, 4, 2, 3, 0);
    t_prog[1][4] = encode(OP_SW, 0, 1, 4, 'h20);
    t_prog[1][5] = encode(OP_LW, 5, 1, 0, 4);
    t_prog[1][6] = encode(OP_ADD, 6, 5, 4, 0);
    t_prog[1][7] = encode(OP_SW, 0, 1, 6, 'h24);
    add_store(1, 32'h60, 32'h1234_5688);
    add_store(1, 32'h64, 32'h1234_5588);
    // Taken BEQ skips two stores and the second BEQ falls through
    t_name[2]    = "branch";
    t_prog[2][0] = encode(OP_ADDI, 1, 0, 0, 1);
    t_prog[2][1] = encode(OP_ADDI, 2, 0, 0, 1);
    t_prog[2][2] = encode(OP_BEQ, 0, 1, 2, 3);
    t_prog[2][3] = encode(OP_SW, 0, 0, 1, 'h50);
    t_prog[2][4] = encode(OP_SW, 0, 0, 2, 'h54);
    t_prog[2][5] = encode(OP_ADDI, 3, 0, 0, 2);
    t_prog[2][6] = encode(OP_BEQ, 0, 1, 3, 5);
    t_prog[2][7] = encode(OP_SW, 0, 0, 3, 'h58);
    t_prog[2][8] = encode(OP_SW, 0, 0, 1, 'h5c);
    add_store(2, 32'h58, 32'h0000_0002);
    add_store(2, 32'h5c, 32'h0000_0001);
  endtask

  // Instruction and data bus slaves with random grant delays
  always begin
    @(posedge clk);
    bus_rst = !arst_n_i;
    #1;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    if (bus_rst) begin
      i_pend  = 1'b0;
      d_pend  = 1'b0;
      i_delay = 0;
      d_delay = 0;
      st_addr_q.delete();
      st_data_q.delete();
      for (int i = 0; i < 64; i++) begin
        imem[i] = (i < ProgLen) ? t_prog[cur_test][i] : encode(OP_ECALL, 0, 0, 0, i);
        dmem[i] = 32'hd0d0_0000 | word_t'(i << 2);
      end
      for (int k = 0; k < 4; k++) begin
        dmem[16 + k] = t_dmem[cur_test][k];
      end
    end else begin
      if (i_pend) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = imem[i_addr[7:2]];
        i_pend         = 1'b0;
      end else if (instr_req_o) begin
        if (i_delay == 0) begin
          instr_gnt_i = 1'b1;
          i_addr      = instr_addr_o;
          i_pend      = 1'b1;
          i_delay     = draw_delay();
        end else begin
          i_delay--;
        end
      end
      if (d_pend) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = dmem[d_addr[7:2]];
        d_pend        = 1'b0;
      end else if (data_req_o) begin
        if (d_delay == 0) begin
          data_gnt_i = 1'b1;
          d_addr     = data_addr_o;
          d_pend     = 1'b1;
          d_delay    = draw_delay();
          if (data_we_o) begin
            dmem[data_addr_o[7:2]] = data_wdata_o;
            st_addr_q.push_back(data_addr_o);
            st_data_q.push_back(data_wdata_o);
          end
        end else begin
          d_delay--;
        end
      end
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_stores(input int t);
    if (st_addr_q.size() != t_nstores[t]) begin
      $display("%s: expected %0d stores, but %0d were logged",
               t_name[t], t_nstores[t], st_addr_q.size());
      errors++;
    end else begin
      for (int k = 0; k < t_nstores[t]; k++) begin
        if (st_addr_q[k] !== t_st_addr[t][k]) begin
          $display("** Error: %s store %0d address: expected %h, actual %h",
                   t_name[t], k, t_st_addr[t][k], st_addr_q[k]);
          errors++;
        end
        if (st_data_q[k] !== t_st_data[t][k]) begin
          $display("** Error: %s store %0d data: expected %h, actual %h",
                   t_name[t], k, t_st_data[t][k], st_data_q[k]);
          errors++;
        end
      end
    end
  endtask

  task automatic run_test(input int t);
    int cycles;
    cur_test       = t;
    fetch_enable_i = 1'b0;
    arst_n_i       = 1'b0;
    repeat (10) step();
    arst_n_i = 1'b1;
    // Core stays quiet until fetch is enabled
    repeat (5) begin
      step();
      if (instr_req_o || data_req_o || core_sleep_o) begin
        $display("%s: request or sleep seen while fetch was disabled", t_name[t]);
        errors++;
      end
    end
    fetch_enable_i = 1'b1;
    cycles = 0;
    while (!core_sleep_o && cycles < 300) begin
      step();
      cycles++;
    end
    if (!core_sleep_o) begin
      $display("%s: core never halted within 300 cycles", t_name[t]);
      errors++;
    end else begin
      repeat (20) begin
        step();
        if (instr_req_o || data_req_o) begin
          $display("%s: bus request seen after the core halted", t_name[t]);
          errors++;
        end
      end
      check_stores(t);
    end
  endtask

  initial begin
    build_table();
    for (int t = 0; t < NumTests; t++) begin
      run_test(t);
    end
    $display("Tests run: %0d, errors: %0d", NumTests, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(Timeout);
    $display("Timeout: run did not finish within %0d ns, errors: %0d", Timeout, errors);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* tiny_core.sv */
`timescale 1ns/1ps
//------------------------------------------------
// BootAddr must be word aligned
// core_sleep_o stays high after ECALL until reset
//------------------------------------------------
module tiny_core #(
  parameter core_pkg::word_t BootAddr = '0
) (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             fetch_enable_i,
  // Instruction port
  output logic             instr_req_o,
  input  logic             instr_gnt_i,
  output core_pkg::word_t  instr_addr_o,
  input  logic             instr_rvalid_i,
  input  core_pkg::instr_t instr_rdata_i,
  // Data port
  output logic             data_req_o,
  input  logic             data_gnt_i,
  output logic             data_we_o,
  output core_pkg::word_t  data_addr_o,
  output core_pkg::word_t  data_wdata_o,
  input  logic             data_rvalid_i,
  input  core_pkg::word_t  data_rdata_i,
  output logic             core_sleep_o
);

  logic halt;

  fetch_if i_fetch_if ();
  lsu_if   i_lsu_if ();

  fetch_unit #(
    .BootAddr(BootAddr)
  ) i_fetch_unit (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .fetch_enable_i(fetch_enable_i),
    .halt_i        (halt),
    .instr_req_o   (instr_req_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_addr_o  (instr_addr_o),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .fetch_bus     (i_fetch_if.fetch)
  );

  exec_unit i_exec_unit (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .fetch_bus(i_fetch_if.exec),
    .lsu_bus  (i_lsu_if.exec),
    .halt_o   (halt)
  );

  lsu i_lsu (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .data_req_o   (data_req_o),
    .data_gnt_i   (data_gnt_i),
    .data_we_o    (data_we_o),
    .data_addr_o  (data_addr_o),
    .data_wdata_o (data_wdata_o),
    .data_rvalid_i(data_rvalid_i),
    .data_rdata_i (data_rdata_i),
    .lsu_bus      (i_lsu_if.lsu)
  );

  assign core_sleep_o = halt;

endmodule
